// File: common/rsched_pkg.sv
// shared widths, buffer depths and enums for the read scheduler RTL and its testbench
package rsched_pkg;

	////////////////////////////////////////////////////////////////////////////
	// word counts and positions
	////////////////////////////////////////////////////////////////////////////

	// word counts and end of packet positions share this width
	localparam int VALID_WIDTH = 4;

	// a single input beat never carries more than this many words
	localparam logic [VALID_WIDTH-1:0] MAX_BEAT_WORDS = VALID_WIDTH'(8);

	// size of a full read group
	localparam logic [VALID_WIDTH-1:0] GROUP_WORDS = VALID_WIDTH'(8);

	////////////////////////////////////////////////////////////////////////////
	// buffer depths
	////////////////////////////////////////////////////////////////////////////

	// entries in the write side beat FIFO
	localparam int WR_FIFO_DEPTH = 16;

	// entries in the read side group FIFO
	localparam int RD_FIFO_DEPTH = 16;

	////////////////////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////////////////////

	// classification of the beat presented to the scheduler
	typedef enum logic [1:0] {
		beat_none = 2'd0,
		beat_mid  = 2'd1,
		beat_eop  = 2'd2
	} beat_kind_e;

	// st_flush lasts one cycle and emits the tail of a long packet head
	typedef enum logic {
		st_accept = 1'b0,
		st_flush  = 1'b1
	} sched_state_e;

endpackage

// File: logic/sync_fifo.sv
// single clock FIFO with registered read data, built for both the beat and group buffers
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
)(
	input  logic             clk_rd,
	input  logic             aclr_rd,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty,
	output logic             full
);

	// storage has no reset, the pointers and count say what is live
	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	assign empty = (count == '0);
	assign full  = (int'(count) == DEPTH);

	// pointers wrap explicitly so any depth works, not only powers of two
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			// occupancy only moves when exactly one side is active
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// write port and registered read port
	// read data shows up the cycle after pop and holds until the next pop
	always_ff @(posedge clk_rd) begin
		if (push)
			mem[wr_ptr] <= push_data;
		if (pop)
			pop_data <= mem[rd_ptr];
	end

	// the owning block gates pop with empty and push with full
	a_no_underflow: assert property (@(posedge clk_rd) disable iff (aclr_rd)
		!(pop && empty));
	a_no_overflow: assert property (@(posedge clk_rd) disable iff (aclr_rd)
		!(push && full));

endmodule

// File: decode/beat_decoder.sv
// registers incoming beats, buffers them in the write FIFO and presents one classified beat
`timescale 1ns/10ps

module beat_decoder (
	input  logic                                clk_rd,
	input  logic                                aclr_rd,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  wr_num_valid,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  wr_eop_position,
	input  logic                                sched_wait,
	output rsched_pkg::beat_kind_e              beat_kind,
	output logic [rsched_pkg::VALID_WIDTH-1:0]  beat_words,
	output logic [rsched_pkg::VALID_WIDTH-1:0]  beat_eop_position,
	output logic                                wr_overflow
);

	////////////////////////////////////////////////////////////////////////////
	// input registers
	////////////////////////////////////////////////////////////////////////////

	logic [rsched_pkg::VALID_WIDTH-1:0] wr_num_valid_r;
	logic [rsched_pkg::VALID_WIDTH-1:0] wr_eop_position_r;

	// these are reset because a nonzero count is itself the write request
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			wr_num_valid_r    <= '0;
			wr_eop_position_r <= '0;
		end else begin
			wr_num_valid_r    <= wr_num_valid;
			wr_eop_position_r <= wr_eop_position;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// write side FIFO
	////////////////////////////////////////////////////////////////////////////

	logic                                 beat_arrived;
	logic                                 wrfifo_push;
	logic                                 wrfifo_pop;
	logic                                 wrfifo_empty;
	logic                                 wrfifo_full;
	logic [2*rsched_pkg::VALID_WIDTH-1:0] wrfifo_q;
	logic                                 held_valid;
	logic                                 beat_consumed;

	// empty beats carry nothing for the scheduler so they never enter the FIFO
	assign beat_arrived = (wr_num_valid_r != '0);
	assign wrfifo_push  = beat_arrived && !wrfifo_full;

	sync_fifo #(
		.WIDTH (2*rsched_pkg::VALID_WIDTH),
		.DEPTH (rsched_pkg::WR_FIFO_DEPTH)
	) i_wr_fifo (
		.clk_rd    (clk_rd),
		.aclr_rd   (aclr_rd),
		.push      (wrfifo_push),
		.push_data ({wr_num_valid_r, wr_eop_position_r}),
		.pop       (wrfifo_pop),
		.pop_data  (wrfifo_q),
		.empty     (wrfifo_empty),
		.full      (wrfifo_full)
	);

	// a beat that finds the FIFO full is lost, the flag stays up until reset
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd)
			wr_overflow <= 1'b0;
		else if (beat_arrived && wrfifo_full)
			wr_overflow <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// held beat toward the scheduler
	////////////////////////////////////////////////////////////////////////////

	// the FIFO output register acts as the holding stage for the presented beat
	assign beat_consumed = held_valid && !sched_wait;
	assign wrfifo_pop    = !wrfifo_empty && (!held_valid || beat_consumed);

	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd)
			held_valid <= 1'b0;
		else if (wrfifo_pop)
			held_valid <= 1'b1;
		else if (beat_consumed)
			held_valid <= 1'b0;
	end

	// FIFO data is masked so an empty stage always shows as zeros
	assign beat_words        = held_valid ? wrfifo_q[2*rsched_pkg::VALID_WIDTH-1:
		rsched_pkg::VALID_WIDTH] : '0;
	assign beat_eop_position = held_valid ? wrfifo_q[rsched_pkg::VALID_WIDTH-1:0] : '0;

	// a nonzero end of packet position marks the beat as closing a packet
	always_comb begin
		if (!held_valid)
			beat_kind = rsched_pkg::beat_none;
		else if (beat_eop_position != '0)
			beat_kind = rsched_pkg::beat_eop;
		else
			beat_kind = rsched_pkg::beat_mid;
	end

	// the beat the scheduler sees must still be well formed after the FIFO
	a_eop_in_beat: assert property (@(posedge clk_rd) disable iff (aclr_rd)
		(beat_kind == rsched_pkg::beat_eop) |->
		(beat_eop_position <= beat_words && beat_words <= rsched_pkg::MAX_BEAT_WORDS));

endmodule

// File: execute/regroup_scheduler.sv
// regroups presented beat word counts into read groups that never cross a packet boundary
`timescale 1ns/10ps

module regroup_scheduler (
	input  logic                                clk_rd,
	input  logic                                aclr_rd,
	input  rsched_pkg::beat_kind_e              beat_kind,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  beat_words,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  beat_eop_position,
	output logic                                sched_wait,
	output logic [rsched_pkg::VALID_WIDTH-1:0]  grp_words
);

	////////////////////////////////////////////////////////////////////////////
	// state
	////////////////////////////////////////////////////////////////////////////

	rsched_pkg::sched_state_e state;
	rsched_pkg::sched_state_e state_nxt;

	// words of the open packet not yet sent, always below a full group
	logic [rsched_pkg::VALID_WIDTH-1:0] acc;
	logic [rsched_pkg::VALID_WIDTH-1:0] acc_nxt;

	// tail of a long packet head that goes out in the flush cycle
	logic [rsched_pkg::VALID_WIDTH-1:0] flush_words;
	logic [rsched_pkg::VALID_WIDTH-1:0] flush_nxt;

	logic [rsched_pkg::VALID_WIDTH-1:0] grp_nxt;

	// acc is at most 7 and a beat at most 8, so 15 still fits the count width
	logic [rsched_pkg::VALID_WIDTH-1:0] sum;
	logic [rsched_pkg::VALID_WIDTH-1:0] head;

	// the decoder holds its beat for as long as a flush is in progress
	assign sched_wait = (state == rsched_pkg::st_flush);

	assign sum  = acc + beat_words;
	assign head = acc + beat_eop_position;

	////////////////////////////////////////////////////////////////////////////
	// next state and group
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		acc_nxt   = acc;
		flush_nxt = flush_words;
		grp_nxt   = '0;
		case (state)
			rsched_pkg::st_accept: begin
				// sched_wait is low here so any present beat is consumed now
				case (beat_kind)
					rsched_pkg::beat_mid: begin
						// the packet continues, send a full group once 8 words are in
						if (sum >= rsched_pkg::GROUP_WORDS) begin
							grp_nxt = rsched_pkg::GROUP_WORDS;
							acc_nxt = sum - rsched_pkg::GROUP_WORDS;
						end else begin
							acc_nxt = sum;
						end
					end
					rsched_pkg::beat_eop: begin
						// head is everything of the closing packet still unsent
						if (head <= rsched_pkg::GROUP_WORDS) begin
							grp_nxt = head;
						end else begin
							// full group now and the rest on the next cycle
							grp_nxt   = rsched_pkg::GROUP_WORDS;
							flush_nxt = head - rsched_pkg::GROUP_WORDS;
							state_nxt = rsched_pkg::st_flush;
						end
						// words after the end of packet open the next packet
						acc_nxt = beat_words - beat_eop_position;
					end
					default: begin
						acc_nxt = acc;
					end
				endcase
			end
			rsched_pkg::st_flush: begin
				// no beat is taken in this cycle, only the stored tail goes out
				grp_nxt   = flush_words;
				flush_nxt = '0;
				state_nxt = rsched_pkg::st_accept;
			end
			default: begin
				state_nxt = rsched_pkg::st_accept;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// groups leave registered, one cycle after the beat that completes them
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			state       <= rsched_pkg::st_accept;
			acc         <= '0;
			flush_words <= '0;
			grp_words   <= '0;
		end else begin
			state       <= state_nxt;
			acc         <= acc_nxt;
			flush_words <= flush_nxt;
			grp_words   <= grp_nxt;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a well formed closing beat always leaves less than a full group open
	a_acc_bound: assert property (@(posedge clk_rd) disable iff (aclr_rd)
		acc < rsched_pkg::GROUP_WORDS);

	// a beat waiting through the flush cycle reaches the next cycle unchanged
	a_wait_holds_beat: assert property (@(posedge clk_rd) disable iff (aclr_rd)
		(sched_wait && beat_kind != rsched_pkg::beat_none) |=>
		(beat_kind == $past(beat_kind) && $stable(beat_words) &&
		$stable(beat_eop_position)));

endmodule

// File: result/read_buffer.sv
// queues read groups from the scheduler, holds them while paused and drives the output count
`timescale 1ns/10ps

module read_buffer (
	input  logic                                clk_rd,
	input  logic                                aclr_rd,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  grp_words,
	input  logic                                rd_pause,
	output logic [rsched_pkg::VALID_WIDTH-1:0]  rd_num_valid,
	output logic                                rd_overflow
);

	logic                               grp_arrived;
	logic                               rdfifo_push;
	logic                               rdfifo_pop;
	logic                               rdfifo_empty;
	logic                               rdfifo_full;
	logic [rsched_pkg::VALID_WIDTH-1:0] rdfifo_q;
	logic                               rdfifo_q_valid;

	////////////////////////////////////////////////////////////////////////////
	// group FIFO
	////////////////////////////////////////////////////////////////////////////

	// the scheduler never waits on this side, a full buffer drops the group
	assign grp_arrived = (grp_words != '0);
	assign rdfifo_push = grp_arrived && !rdfifo_full;

	// the reader side drains whenever it is not paused
	assign rdfifo_pop  = !rdfifo_empty && !rd_pause;

	sync_fifo #(
		.WIDTH (rsched_pkg::VALID_WIDTH),
		.DEPTH (rsched_pkg::RD_FIFO_DEPTH)
	) i_rd_fifo (
		.clk_rd    (clk_rd),
		.aclr_rd   (aclr_rd),
		.push      (rdfifo_push),
		.push_data (grp_words),
		.pop       (rdfifo_pop),
		.pop_data  (rdfifo_q),
		.empty     (rdfifo_empty),
		.full      (rdfifo_full)
	);

	// lost groups are remembered until the next reset
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd)
			rd_overflow <= 1'b0;
		else if (grp_arrived && rdfifo_full)
			rd_overflow <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////////////

	// read data is fresh only in the cycle right after a pop
	// the output register then zeroes every cycle without a new group
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			rdfifo_q_valid <= 1'b0;
			rd_num_valid   <= '0;
		end else begin
			rdfifo_q_valid <= rdfifo_pop;
			rd_num_valid   <= rdfifo_q_valid ? rdfifo_q : '0;
		end
	end

endmodule

// File: logic/buffered_read_scheduler.sv
// top level of the buffered read scheduler, connects decoder, scheduler and read buffer
`timescale 1ns/10ps

module buffered_read_scheduler (
	input  logic                                clk_rd,
	input  logic                                aclr_rd,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  wr_num_valid,
	input  logic [rsched_pkg::VALID_WIDTH-1:0]  wr_eop_position,
	input  logic                                rd_pause,
	output logic [rsched_pkg::VALID_WIDTH-1:0]  rd_num_valid,
	output logic                                wr_overflow,
	output logic                                rd_overflow
);

	////////////////////////////////////////////////////////////////////////////
	// decoder to scheduler
	////////////////////////////////////////////////////////////////////////////

	rsched_pkg::beat_kind_e             beat_kind;
	logic [rsched_pkg::VALID_WIDTH-1:0] beat_words;
	logic [rsched_pkg::VALID_WIDTH-1:0] beat_eop_position;
	logic                               sched_wait;

	// scheduler to read buffer, nonzero for one cycle per group
	logic [rsched_pkg::VALID_WIDTH-1:0] grp_words;

	beat_decoder i_beat_decoder (
		.clk_rd            (clk_rd),
		.aclr_rd           (aclr_rd),
		.wr_num_valid      (wr_num_valid),
		.wr_eop_position   (wr_eop_position),
		.sched_wait        (sched_wait),
		.beat_kind         (beat_kind),
		.beat_words        (beat_words),
		.beat_eop_position (beat_eop_position),
		.wr_overflow       (wr_overflow)
	);

	regroup_scheduler i_regroup_scheduler (
		.clk_rd            (clk_rd),
		.aclr_rd           (aclr_rd),
		.beat_kind         (beat_kind),
		.beat_words        (beat_words),
		.beat_eop_position (beat_eop_position),
		.sched_wait        (sched_wait),
		.grp_words         (grp_words)
	);

	read_buffer i_read_buffer (
		.clk_rd       (clk_rd),
		.aclr_rd      (aclr_rd),
		.grp_words    (grp_words),
		.rd_pause     (rd_pause),
		.rd_num_valid (rd_num_valid),
		.rd_overflow  (rd_overflow)
	);

endmodule

// File: tests/tb_ref_model.svh
// reference model for the read scheduler testbench, included inside the testbench module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// expected groups
////////////////////////////////////////////////////////////////////////////

// group sizes the DUT still owes, oldest first
int exp_q[$];

// a packet of len words leaves as full groups and then whatever is left over
// groups never straddle packets, so every packet is modelled on its own
function automatic void push_expected_groups(input int len);
	int group_size;
	int full_groups;
	int tail;
	group_size  = int'(rsched_pkg::GROUP_WORDS);
	full_groups = len / group_size;
	tail        = len % group_size;
	for (int i = 0; i < full_groups; i++)
		exp_q.push_back(group_size);
	// an exact multiple of the group size has no short closing group
	if (tail != 0)
		exp_q.push_back(tail);
endfunction

`endif

// File: tests/tb_buffered_read_scheduler.sv
// testbench for the buffered read scheduler, run from the Makefile through src.f
`timescale 1ns/10ps

module tb_buffered_read_scheduler;

	// the tests take roughly 3000 cycles, the limit leaves a wide margin
	localparam int CYCLE_LIMIT   = 20000;
	localparam int DRAIN_LIMIT   = 400;
	localparam int SETTLE_CYCLES = 12;

	logic                               clk_rd;
	logic                               aclr_rd;
	logic [rsched_pkg::VALID_WIDTH-1:0] wr_num_valid;
	logic [rsched_pkg::VALID_WIDTH-1:0] wr_eop_position;
	logic                               rd_pause;
	logic [rsched_pkg::VALID_WIDTH-1:0] rd_num_valid;
	logic                               wr_overflow;
	logic                               rd_overflow;

	integer seed;
	bit     check_en;
	bit     pause_rand;
	int     errors;
	int     errors_at_start;
	int     tests_passed;
	int     tests_failed;
	int     cycle_count;
	int     expected;

	`include "tb_ref_model.svh"

	buffered_read_scheduler i_buffered_read_scheduler (
		.clk_rd          (clk_rd),
		.aclr_rd         (aclr_rd),
		.wr_num_valid    (wr_num_valid),
		.wr_eop_position (wr_eop_position),
		.rd_pause        (rd_pause),
		.rd_num_valid    (rd_num_valid),
		.wr_overflow     (wr_overflow),
		.rd_overflow     (rd_overflow)
	);

	always #2 clk_rd = ~clk_rd;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + r % (hi - lo + 1);
	endfunction

	task automatic report_mismatch(input string name, input int exp_val, input int act_val);
		$display("FAILED %s expected 0x%0h got 0x%0h at %0t", name, exp_val, act_val, $time);
		errors++;
	endtask

	// every input change happens just after a falling edge
	task automatic next_cycle();
		@(negedge clk_rd);
		if (pause_rand)
			rd_pause = (rand_range(0, 5) == 0);
	endtask

	task automatic drive_beat(input int words, input int eop_pos);
		next_cycle();
		wr_num_valid    = words[rsched_pkg::VALID_WIDTH-1:0];
		wr_eop_position = eop_pos[rsched_pkg::VALID_WIDTH-1:0];
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			next_cycle();
			wr_num_valid    = '0;
			wr_eop_position = '0;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_rd);
		aclr_rd = 1'b1;
		repeat (4) @(negedge clk_rd);
		aclr_rd = 1'b0;
	endtask

	// beat_size 0 picks a random size per beat and a random extra gap
	task automatic send_packet(input int len, input int beat_size, input int gap);
		int left;
		int size;
		push_expected_groups(len);
		left = len;
		while (left > 0) begin
			size = (beat_size == 0) ? rand_range(1, 8) : beat_size;
			if (size >= left) begin
				// the last beat of the packet ends on its final word
				drive_beat(left, left);
				left = 0;
			end else begin
				drive_beat(size, 0);
				left = left - size;
			end
			idle_cycles(gap + ((beat_size == 0) ? rand_range(0, 2) : 0));
		end
	endtask

	task automatic end_test(input string name);
		int waited;
		idle_cycles(1);
		waited = 0;
		// the queue is popped on falling edges, so it is polled on rising ones
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk_rd);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("test %s: %0d expected groups never arrived", name, exp_q.size());
			errors++;
			exp_q.delete();
		end
		repeat (SETTLE_CYCLES) @(posedge clk_rd);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s finished without errors", name);
		end else begin
			tests_failed++;
			$display("test %s finished with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare process and cycle limit
	////////////////////////////////////////////////////////////////////////////

	// rd_num_valid changes on rising edges, so it is settled at the falling edge
	always @(negedge clk_rd) begin
		if (!aclr_rd && check_en && rd_num_valid != '0) begin
			if (exp_q.size() == 0) begin
				$display("a group of %0d words arrived when none was expected", rd_num_valid);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				if (int'(rd_num_valid) != expected)
					report_mismatch("rd_num_valid", expected, int'(rd_num_valid));
			end
		end
	end

	always @(posedge clk_rd) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped after the cycle limit of %0d was reached", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int lens[7]     = '{1, 7, 8, 9, 15, 16, 20};
		int mix_words[8] = '{6, 8, 6, 8, 3, 7, 8, 2};
		int mix_eop[8]   = '{0, 5, 2, 0, 3, 0, 1, 2};
		int mix_lens[5]  = '{11, 5, 15, 8, 9};
		seed            = 32'h2aab_9db2;
		clk_rd          = 1'b0;
		aclr_rd         = 1'b1;
		wr_num_valid    = '0;
		wr_eop_position = '0;
		rd_pause        = 1'b0;
		check_en        = 1'b1;
		pause_rand      = 1'b0;
		errors          = 0;
		errors_at_start = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		cycle_count     = 0;
		apply_reset();

		// outputs stay quiet while nothing is sent
		for (int i = 0; i < 20; i++) begin
			@(negedge clk_rd);
			if (rd_num_valid != '0)
				report_mismatch("rd_num_valid", 0, int'(rd_num_valid));
			if (wr_overflow != 1'b0)
				report_mismatch("wr_overflow", 0, int'(wr_overflow));
			if (rd_overflow != 1'b0)
				report_mismatch("rd_overflow", 0, int'(rd_overflow));
		end
		end_test("1 idle after reset");

		// single packets cut into full beats and then into short 3 word beats
		foreach (lens[i]) begin
			send_packet(lens[i], 8, 1);
			idle_cycles(10);
			send_packet(lens[i], 3, 1);
			idle_cycles(10);
		end
		end_test("2 single packets");

		// beats that close one packet and open the next, once back to back and once spaced
		for (int pass = 0; pass < 2; pass++) begin
			foreach (mix_lens[i])
				push_expected_groups(mix_lens[i]);
			foreach (mix_words[i]) begin
				drive_beat(mix_words[i], mix_eop[i]);
				idle_cycles(pass * 2);
			end
			idle_cycles(10);
		end
		end_test("3 shared beats");

		// light random traffic with short read pauses
		pause_rand = 1'b1;
		for (int p = 0; p < 40; p++)
			send_packet(rand_range(1, 40), 0, 2);
		pause_rand = 1'b0;
		rd_pause   = 1'b0;
		idle_cycles(20);
		if (wr_overflow != 1'b0)
			report_mismatch("wr_overflow", 0, int'(wr_overflow));
		if (rd_overflow != 1'b0)
			report_mismatch("rd_overflow", 0, int'(rd_overflow));
		end_test("4 random packets");

		// 40 full groups against a paused reader and a 16 entry group buffer
		check_en = 1'b0;
		rd_pause = 1'b1;
		for (int i = 0; i < 40; i++)
			drive_beat(8, 8);
		idle_cycles(10);
		if (rd_overflow != 1'b1)
			report_mismatch("rd_overflow", 1, int'(rd_overflow));
		apply_reset();
		if (rd_overflow != 1'b0)
			report_mismatch("rd_overflow", 0, int'(rd_overflow));
		rd_pause = 1'b0;
		check_en = 1'b1;
		end_test("5 read overflow");

		// each 7 plus 8 pair costs three scheduler cycles for two input cycles
		check_en = 1'b0;
		for (int i = 0; i < 48; i++) begin
			drive_beat(7, 0);
			drive_beat(8, 8);
		end
		idle_cycles(3);
		if (wr_overflow != 1'b1)
			report_mismatch("wr_overflow", 1, int'(wr_overflow));
		apply_reset();
		if (wr_overflow != 1'b0)
			report_mismatch("wr_overflow", 0, int'(wr_overflow));
		check_en = 1'b1;
		end_test("6 write overflow");

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+tests
common/rsched_pkg.sv
logic/sync_fifo.sv
decode/beat_decoder.sv
execute/regroup_scheduler.sv
result/read_buffer.sv
logic/buffered_read_scheduler.sv
tests/tb_buffered_read_scheduler.sv

// File: Makefile
# Verilator build and run of the buffered read scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_buffered_read_scheduler
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source is newer than the binary
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
